/* hdl/io_pkg.sv */
package io_pkg;

  localparam int IO_NUM_SLOTS  = 16;
  localparam int IO_DATA_WIDTH = 16;

  // One address bit per register slot
  typedef logic [IO_NUM_SLOTS-1:0]  io_addr_t;
  typedef logic [IO_DATA_WIDTH-1:0] io_data_t;

  // Value is the address bit that selects the slot
  typedef enum logic [$clog2(IO_NUM_SLOTS)-1:0] {
    SLOT_PORTA_IN     = 4'd0,
    SLOT_PORTA_OUT    = 4'd1,
    SLOT_PORTA_DIR    = 4'd2,
    SLOT_LEDS         = 4'd3,
    SLOT_PORTB_IN     = 4'd4,
    SLOT_PORTB_OUT    = 4'd5,
    SLOT_PORTB_DIR    = 4'd6,
    SLOT_SRAM_DATA    = 4'd7,
    SLOT_PORTC_IN     = 4'd8,
    SLOT_PORTC_OUT    = 4'd9,
    SLOT_PORTC_DIR    = 4'd10,
    SLOT_SRAM_ADDR_LO = 4'd11,
    SLOT_TICKS        = 4'd14,
    SLOT_SRAM_ADDR_HI = 4'd15
  } io_slot_e;

  // One-hot bus address of a slot
  function automatic io_addr_t slot_addr(io_slot_e slot);
    return io_addr_t'(1) << slot;
  endfunction

endpackage

/* hdl/board_pkg.sv */
package board_pkg;

  // Each GPIO port is one full bus word wide
  localparam int GPIO_WIDTH = 16;
  typedef logic [GPIO_WIDTH-1:0] gpio_t;

  // 512K x 16 external SRAM
  localparam int SRAM_ADDR_WIDTH = 19;
  typedef logic [SRAM_ADDR_WIDTH-1:0] sram_addr_t;

  // Address bits above the 16-bit low slot
  localparam int SRAM_ADDR_HI_WIDTH = 3;

  // Board LEDs
  localparam int LED_COUNT = 4;
  typedef logic [LED_COUNT-1:0] led_t;

endpackage

/* hdl/io_bus_if.sv */
interface io_bus_if
  import io_pkg::*;
();

  logic     wr;
  io_addr_t addr;
  io_data_t wdata;
  // OR of all selected slots or zero when none is selected
  io_data_t rdata;

  modport host (
    output wr,
    output addr,
    output wdata,
    input  rdata
  );

  modport peripheral (
    input  wr,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

/* hdl/gpio_port.sv */
module gpio_port
  import board_pkg::*;
#(
  // Slot of the pin input; out and dir follow directly above it
  parameter int unsigned BASE_SLOT = 0
)
(
  input  logic         clk,
  input  logic         reset_extern,
  io_bus_if.peripheral bus,
  input  gpio_t        pin_in,
  output gpio_t        pin_out,
  output gpio_t        pin_oe
);

  logic sel_in;
  logic sel_out;
  logic sel_dir;

  assign sel_in  = bus.addr[BASE_SLOT];
  assign sel_out = bus.addr[BASE_SLOT + 1];
  assign sel_dir = bus.addr[BASE_SLOT + 2];

  // Direction bit 1 drives the pin
  always_ff @(posedge clk)
  begin
    if (reset_extern)
    begin
      pin_out <= '0;
      pin_oe  <= '0;
    end
    else
    begin
      if (bus.wr && sel_out)
        pin_out <= bus.wdata;
      if (bus.wr && sel_dir)
        pin_oe <= bus.wdata;
    end
  end

  // Readback of the three slots
  assign bus.rdata = (sel_in  ? pin_in  : '0)
                   | (sel_out ? pin_out : '0)
                   | (sel_dir ? pin_oe  : '0);

endmodule

/* hdl/sram_port.sv */
module sram_port
  import io_pkg::*;
  import board_pkg::*;
(
  input  logic         clk,
  input  logic         reset_extern,
  io_bus_if.peripheral bus,
  output sram_addr_t   sram_addr,
  output io_data_t     sram_data_out,
  input  io_data_t     sram_data_in,
  output logic         sram_data_oe,
  output logic         sram_we_n,
  output logic         sram_oe_n
);

  localparam int ADDR_LO_WIDTH = SRAM_ADDR_WIDTH - SRAM_ADDR_HI_WIDTH;

  logic sel_data;
  logic sel_addr_lo;
  logic sel_addr_hi;
  logic drive;

  assign sel_data    = |(bus.addr & slot_addr(SLOT_SRAM_DATA));
  assign sel_addr_lo = |(bus.addr & slot_addr(SLOT_SRAM_ADDR_LO));
  assign sel_addr_hi = |(bus.addr & slot_addr(SLOT_SRAM_ADDR_HI));

  // Address is set in two halves
  always_ff @(posedge clk)
  begin
    if (bus.wr && sel_addr_lo)
      sram_addr[ADDR_LO_WIDTH-1:0] <= bus.wdata;
    if (bus.wr && sel_addr_hi)
      sram_addr[SRAM_ADDR_WIDTH-1 -: SRAM_ADDR_HI_WIDTH] <= bus.wdata[SRAM_ADDR_HI_WIDTH-1:0];
    if (bus.wr && sel_data)
      sram_data_out <= bus.wdata;
  end

  // Write cycle lasts exactly one clock after the data write
  always_ff @(posedge clk)
  begin
    if (reset_extern)
      drive <= 1'b0;
    else
      drive <= bus.wr && sel_data;
  end

  // Chip output enabled whenever we are not writing
  assign sram_data_oe = drive;
  assign sram_we_n    = ~drive;
  assign sram_oe_n    = drive;

  assign bus.rdata = (sel_data    ? sram_data_in                                    : '0)
                   | (sel_addr_lo ? io_data_t'(sram_addr[ADDR_LO_WIDTH-1:0])        : '0)
                   | (sel_addr_hi ? io_data_t'(sram_addr[SRAM_ADDR_WIDTH-1 -:
                                                         SRAM_ADDR_HI_WIDTH])      : '0);

endmodule

/* hdl/io_sysctl.sv */
module io_sysctl
  import io_pkg::*;
  import board_pkg::*;
(
  input  logic     clk,
  input  logic     reset_extern,
  input  logic     io_wr,
  input  io_addr_t io_addr,
  input  io_data_t io_dout,
  output io_data_t io_din,
  output logic     interrupt,
  output led_t     leds,
  io_bus_if.host   porta_bus,
  io_bus_if.host   portb_bus,
  io_bus_if.host   portc_bus,
  io_bus_if.host   sram_bus
);

  logic     sel_leds;
  logic     sel_ticks;
  logic     ticks_load;
  io_data_t ticks;
  io_data_t local_rdata;

  // Single master, so every peripheral sees the same bus
  assign porta_bus.wr    = io_wr;
  assign porta_bus.addr  = io_addr;
  assign porta_bus.wdata = io_dout;

  assign portb_bus.wr    = io_wr;
  assign portb_bus.addr  = io_addr;
  assign portb_bus.wdata = io_dout;

  assign portc_bus.wr    = io_wr;
  assign portc_bus.addr  = io_addr;
  assign portc_bus.wdata = io_dout;

  assign sram_bus.wr     = io_wr;
  assign sram_bus.addr   = io_addr;
  assign sram_bus.wdata  = io_dout;

  assign sel_leds   = |(io_addr & slot_addr(SLOT_LEDS));
  assign sel_ticks  = |(io_addr & slot_addr(SLOT_TICKS));
  assign ticks_load = io_wr && sel_ticks;

  // Free-running tick counter, loadable from the bus
  always_ff @(posedge clk)
  begin
    if (reset_extern)
      ticks <= '0;
    else if (ticks_load)
      ticks <= io_dout;
    else
      ticks <= ticks + 1'b1;
  end

  // Pulse once when the counter wraps; a load on that edge suppresses it
  always_ff @(posedge clk)
  begin
    if (reset_extern)
      interrupt <= 1'b0;
    else
      interrupt <= (&ticks) && !ticks_load;
  end

  always_ff @(posedge clk)
  begin
    if (reset_extern)
      leds <= '0;
    else if (io_wr && sel_leds)
      leds <= io_dout[LED_COUNT-1:0];
  end

  assign local_rdata = (sel_leds  ? io_data_t'(leds) : '0)
                     | (sel_ticks ? ticks            : '0);

  // Peers share the bus, read data is simply ORed
  assign io_din = local_rdata
                | porta_bus.rdata
                | portb_bus.rdata
                | portc_bus.rdata
                | sram_bus.rdata;

endmodule

/* hdl/io_peripherals.sv */
module io_peripherals
  import io_pkg::*;
  import board_pkg::*;
#(
  parameter int unsigned PORTA_BASE = 0,
  parameter int unsigned PORTB_BASE = 4,
  parameter int unsigned PORTC_BASE = 8
)
(
  input  logic       clk,
  input  logic       reset_extern,

  // CPU I/O bus
  input  logic       io_wr,
  // Read strobe has no consumer once the UART is gone
  input  logic       io_rd,
  input  io_addr_t   io_addr,
  input  io_data_t   io_dout,
  output io_data_t   io_din,
  output logic       interrupt,

  output led_t       leds,

  input  gpio_t      porta_pin_in,
  output gpio_t      porta_pin_out,
  output gpio_t      porta_pin_oe,
  input  gpio_t      portb_pin_in,
  output gpio_t      portb_pin_out,
  output gpio_t      portb_pin_oe,
  input  gpio_t      portc_pin_in,
  output gpio_t      portc_pin_out,
  output gpio_t      portc_pin_oe,

  output sram_addr_t sram_addr,
  output io_data_t   sram_data_out,
  input  io_data_t   sram_data_in,
  output logic       sram_data_oe,
  output logic       sram_we_n,
  output logic       sram_oe_n
);

  io_bus_if porta_bus ();
  io_bus_if portb_bus ();
  io_bus_if portc_bus ();
  io_bus_if sram_bus ();

  io_sysctl u_io_sysctl (
    .clk          (clk),
    .reset_extern (reset_extern),
    .io_wr        (io_wr),
    .io_addr      (io_addr),
    .io_dout      (io_dout),
    .io_din       (io_din),
    .interrupt    (interrupt),
    .leds         (leds),
    .porta_bus    (porta_bus),
    .portb_bus    (portb_bus),
    .portc_bus    (portc_bus),
    .sram_bus     (sram_bus)
  );

  gpio_port #(
    .BASE_SLOT (PORTA_BASE)
  ) u_porta (
    .clk          (clk),
    .reset_extern (reset_extern),
    .bus          (porta_bus),
    .pin_in       (porta_pin_in),
    .pin_out      (porta_pin_out),
    .pin_oe       (porta_pin_oe)
  );

  gpio_port #(
    .BASE_SLOT (PORTB_BASE)
  ) u_portb (
    .clk          (clk),
    .reset_extern (reset_extern),
    .bus          (portb_bus),
    .pin_in       (portb_pin_in),
    .pin_out      (portb_pin_out),
    .pin_oe       (portb_pin_oe)
  );

  gpio_port #(
    .BASE_SLOT (PORTC_BASE)
  ) u_portc (
    .clk          (clk),
    .reset_extern (reset_extern),
    .bus          (portc_bus),
    .pin_in       (portc_pin_in),
    .pin_out      (portc_pin_out),
    .pin_oe       (portc_pin_oe)
  );

  sram_port u_sram_port (
    .clk           (clk),
    .reset_extern  (reset_extern),
    .bus           (sram_bus),
    .sram_addr     (sram_addr),
    .sram_data_out (sram_data_out),
    .sram_data_in  (sram_data_in),
    .sram_data_oe  (sram_data_oe),
    .sram_we_n     (sram_we_n),
    .sram_oe_n     (sram_oe_n)
  );

endmodule

/* verification/io_peripherals_checker.sv */
module io_peripherals_checker
  import io_pkg::*;
  import board_pkg::*;
(
  input logic       clk,
  input logic       reset_extern,
  input logic       io_wr,
  input io_addr_t   io_addr,
  input io_data_t   io_dout,
  input io_data_t   io_din,
  input logic       interrupt,
  input led_t       leds,
  input gpio_t      porta_pin_in, porta_pin_out, porta_pin_oe,
  input gpio_t      portb_pin_in, portb_pin_out, portb_pin_oe,
  input gpio_t      portc_pin_in, portc_pin_out, portc_pin_oe,
  input sram_addr_t sram_addr,
  input io_data_t   sram_data_out,
  input io_data_t   sram_data_in,
  input logic       sram_data_oe, sram_we_n, sram_oe_n
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int LO_W = SRAM_ADDR_WIDTH - SRAM_ADDR_HI_WIDTH;
  // Interrupt, data drive, we_n, oe_n, LEDs, then all pin enables
  localparam logic [55:0] RESET_VIEW = {8'h20, 48'h0};

  int error_count = 0;

  // Bus cycle seen one edge earlier
  logic     reset_q     = 1'b0;
  logic     wr_q        = 1'b0;
  io_addr_t addr_q      = '0;
  io_data_t dout_q      = '0;
  io_data_t din_q       = '0;
  logic     tick_rd_q   = 1'b0;
  logic     interrupt_q = 1'b0;

  io_addr_t    ticks_addr;
  io_data_t    slot_val [IO_NUM_SLOTS];
  io_data_t    exp_din;
  logic [2:0]  exp_strobe;
  logic [55:0] reset_view;

  function automatic void report_mismatch(input string name, input logic [63:0] expected,
                                          input logic [63:0] actual);
    error_count++;
    $error("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, expected, actual);
  endfunction

  assign ticks_addr = slot_addr(SLOT_TICKS);
  assign reset_view = {interrupt, sram_data_oe, sram_we_n, sram_oe_n, leds,
                       porta_pin_oe, portb_pin_oe, portc_pin_oe};

  always @(posedge clk)
  begin
    reset_q     <= reset_extern;
    wr_q        <= io_wr;
    addr_q      <= io_addr;
    dout_q      <= io_dout;
    din_q       <= io_din;
    tick_rd_q   <= !io_wr && (io_addr == ticks_addr);
    interrupt_q <= interrupt;
  end

  // Slot values in address-bit order, ticks slot left at zero
  assign slot_val = '{porta_pin_in, porta_pin_out, porta_pin_oe, io_data_t'(leds),
                      portb_pin_in, portb_pin_out, portb_pin_oe, sram_data_in,
                      portc_pin_in, portc_pin_out, portc_pin_oe, sram_addr[LO_W-1:0],
                      '0, '0, '0, io_data_t'(sram_addr[SRAM_ADDR_WIDTH-1:LO_W])};

  always_comb
  begin
    exp_din = '0;
    for (int i = 0; i < IO_NUM_SLOTS; i++)
      if (io_addr[i])
        exp_din = exp_din | slot_val[i];
  end

  // Drive, we_n, oe_n for the cycle after a data write, idle otherwise
  assign exp_strobe = (wr_q && addr_q[SLOT_SRAM_DATA]) ? 3'b101 : 3'b010;

  assert property (@(posedge clk) reset_q |-> reset_view == RESET_VIEW)
    else report_mismatch("outputs after reset", RESET_VIEW, $sampled(reset_view));

  // GPIO registers load one edge after the write
  assert property (@(posedge clk) disable iff (reset_extern)
    wr_q && addr_q[SLOT_PORTA_OUT] |-> porta_pin_out == dout_q)
    else report_mismatch("porta_pin_out", $sampled(dout_q), $sampled(porta_pin_out));
  assert property (@(posedge clk) disable iff (reset_extern)
    wr_q && addr_q[SLOT_PORTA_DIR] |-> porta_pin_oe == dout_q)
    else report_mismatch("porta_pin_oe", $sampled(dout_q), $sampled(porta_pin_oe));
  assert property (@(posedge clk) disable iff (reset_extern)
    wr_q && addr_q[SLOT_PORTB_OUT] |-> portb_pin_out == dout_q)
    else report_mismatch("portb_pin_out", $sampled(dout_q), $sampled(portb_pin_out));
  assert property (@(posedge clk) disable iff (reset_extern)
    wr_q && addr_q[SLOT_PORTB_DIR] |-> portb_pin_oe == dout_q)
    else report_mismatch("portb_pin_oe", $sampled(dout_q), $sampled(portb_pin_oe));
  assert property (@(posedge clk) disable iff (reset_extern)
    wr_q && addr_q[SLOT_PORTC_OUT] |-> portc_pin_out == dout_q)
    else report_mismatch("portc_pin_out", $sampled(dout_q), $sampled(portc_pin_out));
  assert property (@(posedge clk) disable iff (reset_extern)
    wr_q && addr_q[SLOT_PORTC_DIR] |-> portc_pin_oe == dout_q)
    else report_mismatch("portc_pin_oe", $sampled(dout_q), $sampled(portc_pin_oe));

  assert property (@(posedge clk) disable iff (reset_extern)
    wr_q && addr_q[SLOT_LEDS] |-> leds == dout_q[LED_COUNT-1:0])
    else report_mismatch("leds", $sampled(dout_q[LED_COUNT-1:0]), $sampled(leds));

  // Combinational readback, OR of all selected slots
  assert property (@(posedge clk) disable iff (reset_extern)
    !io_addr[SLOT_TICKS] |-> io_din == exp_din)
    else report_mismatch("io_din", $sampled(exp_din), $sampled(io_din));

  assert property (@(posedge clk) disable iff (reset_extern)
    wr_q && addr_q[SLOT_SRAM_ADDR_LO] |-> sram_addr[LO_W-1:0] == dout_q)
    else report_mismatch("sram_addr low", $sampled(dout_q), $sampled(sram_addr[LO_W-1:0]));
  assert property (@(posedge clk) disable iff (reset_extern)
    wr_q && addr_q[SLOT_SRAM_ADDR_HI] |->
      sram_addr[SRAM_ADDR_WIDTH-1:LO_W] == dout_q[SRAM_ADDR_HI_WIDTH-1:0])
    else report_mismatch("sram_addr high", $sampled(dout_q[SRAM_ADDR_HI_WIDTH-1:0]),
                         $sampled(sram_addr[SRAM_ADDR_WIDTH-1:LO_W]));
  assert property (@(posedge clk) disable iff (reset_extern)
    wr_q && addr_q[SLOT_SRAM_DATA] |-> sram_data_out == dout_q)
    else report_mismatch("sram_data_out", $sampled(dout_q), $sampled(sram_data_out));
  assert property (@(posedge clk) disable iff (reset_extern)
    {sram_data_oe, sram_we_n, sram_oe_n} == exp_strobe)
    else report_mismatch("sram_data_oe/sram_we_n/sram_oe_n", $sampled(exp_strobe),
                         $sampled({sram_data_oe, sram_we_n, sram_oe_n}));

  // Tick counter seen through back-to-back reads
  assert property (@(posedge clk) disable iff (reset_extern)
    tick_rd_q && (io_addr == ticks_addr) |-> io_din == io_data_t'(din_q + 16'd1))
    else report_mismatch("io_din", $sampled(io_data_t'(din_q + 16'd1)), $sampled(io_din));
  assert property (@(posedge clk) disable iff (reset_extern)
    tick_rd_q |-> interrupt == (din_q == 16'hFFFF))
    else report_mismatch("interrupt", $sampled(din_q == 16'hFFFF), $sampled(interrupt));
  assert property (@(posedge clk) disable iff (reset_extern)
    interrupt_q |-> !interrupt)
    else report_mismatch("interrupt", 64'h0, $sampled(interrupt));

endmodule

bind io_peripherals io_peripherals_checker u_checker (.*);

/* verification/tb_io_peripherals.sv */
module tb_io_peripherals
  import io_pkg::*;
  import board_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 20;

  logic       clk;
  logic       reset_extern;
  logic       io_wr;
  logic       io_rd;
  io_addr_t   io_addr;
  io_data_t   io_dout;
  io_data_t   io_din;
  logic       interrupt;
  led_t       leds;
  gpio_t      porta_pin_in, porta_pin_out, porta_pin_oe;
  gpio_t      portb_pin_in, portb_pin_out, portb_pin_oe;
  gpio_t      portc_pin_in, portc_pin_out, portc_pin_oe;
  sram_addr_t sram_addr;
  io_data_t   sram_data_out;
  io_data_t   sram_data_in;
  logic       sram_data_oe;
  logic       sram_we_n;
  logic       sram_oe_n;

  io_peripherals u_io_peripherals (.*);

  always #50 clk = ~clk;

  task automatic fail_run(input string reason);
    $display("ERRORS FOUND");
    $fatal(1, "%s", reason);
  endtask

  // One bus cycle; pins and SRAM data get fresh random values every cycle
  task automatic drive_cycle(input logic wr, input io_addr_t addr, input io_data_t data);
    @(posedge clk);
    io_wr        <= wr;
    io_rd        <= !wr;
    io_addr      <= addr;
    io_dout      <= data;
    porta_pin_in <= gpio_t'($urandom);
    portb_pin_in <= gpio_t'($urandom);
    portc_pin_in <= gpio_t'($urandom);
    sram_data_in <= io_data_t'($urandom);
  endtask

  always @(posedge clk)
  begin
    if (u_io_peripherals.u_checker.error_count != 0)
      fail_run("the checker reported a failed assertion");
  end

  initial
  begin
    int       cycles;
    io_addr_t addr;
    void'($urandom(32'h5489));
    clk          = 1'b0;
    reset_extern = 1'b1;
    io_wr        = 1'b0;
    io_rd        = 1'b0;
    io_addr      = '0;
    io_dout      = '0;
    porta_pin_in = '0;
    portb_pin_in = '0;
    portc_pin_in = '0;
    sram_data_in = '0;
    repeat (3) @(posedge clk);
    reset_extern <= 1'b0;

    // Write each slot except ticks, then read it alone
    repeat (3)
    begin
      for (int s = 0; s < IO_NUM_SLOTS; s++)
      begin
        if (s != SLOT_TICKS)
        begin
          drive_cycle(1'b1, io_addr_t'(1) << s, io_data_t'($urandom));
          drive_cycle(1'b0, io_addr_t'(1) << s, '0);
        end
      end
    end

    // Back-to-back SRAM data writes
    repeat (2) drive_cycle(1'b1, slot_addr(SLOT_SRAM_DATA), io_data_t'($urandom));
    drive_cycle(1'b0, '0, '0);

    // Two slots at once, one from each address byte
    repeat (40)
    begin
      addr = (io_addr_t'(1) << $urandom_range(7)) | (io_addr_t'(1) << (8 + $urandom_range(7)));
      addr[SLOT_TICKS] = 1'b0;
      drive_cycle(($urandom % 4) == 0, addr, io_data_t'($urandom));
    end

    // Counter runs, then is loaded close to overflow
    repeat (4) drive_cycle(1'b0, slot_addr(SLOT_TICKS), '0);
    drive_cycle(1'b1, slot_addr(SLOT_TICKS), 16'hFFFD);
    cycles = 0;
    do
    begin
      drive_cycle(1'b0, slot_addr(SLOT_TICKS), '0);
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT)
        fail_run("timed out waiting for the tick overflow interrupt");
    end
    while (!interrupt);
    repeat (3) drive_cycle(1'b0, slot_addr(SLOT_TICKS), '0);

    repeat (2) drive_cycle(1'b0, '0, '0);
    @(negedge clk);
    if (u_io_peripherals.u_checker.error_count != 0)
      fail_run("the checker reported a failed assertion");
    else
    begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

/* filelist.f */
hdl/io_pkg.sv
hdl/board_pkg.sv
hdl/io_bus_if.sv
hdl/gpio_port.sv
hdl/sram_port.sv
hdl/io_sysctl.sv
hdl/io_peripherals.sv
verification/io_peripherals_checker.sv
verification/tb_io_peripherals.sv

/* Makefile */
SIM := obj_dir/Vtb_io_peripherals

.PHONY: run clean

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -q "^NO ERRORS$$"

$(SIM): filelist.f $(shell cat filelist.f)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_io_peripherals -f filelist.f

clean:
	rm -rf obj_dir
